// File: design/fixedPointPkg.sv
`default_nettype none

// number format shared by every stage of the network
package fixedPointPkg;

	// ------------------------------------------------------------------------
	// word format
	// ------------------------------------------------------------------------
	localparam int activationWidth = 32; // inputs, products, sums and outputs

	typedef logic [activationWidth-1:0] activation_t;

	// ------------------------------------------------------------------------
	// rescaling after the sum
	// ------------------------------------------------------------------------
	// the ReLU output keeps sum bits 28..13, zero extended to a full word
	localparam int fracBits = 13; // lowest kept sum bit
	localparam int keptBits = 16; // number of kept sum bits

endpackage

`default_nettype wire

// File: design/networkPkg.sv
`default_nettype none

// shape of the classifier and its fixed weight tables
package networkPkg;

	// ------------------------------------------------------------------------
	// network shape
	// ------------------------------------------------------------------------
	localparam int featureCount = 15;
	localparam int hiddenCount = 8;
	localparam int classCount = 3;

	localparam int neuronLatency = 3; // input reg, sum reg, output reg

	typedef logic [$clog2(classCount)-1:0] classIndex_t;

	// ------------------------------------------------------------------------
	// hidden layer, one row of weights per neuron
	// ------------------------------------------------------------------------
	// words are two's complement, only the low 32 bits of each product count
	localparam fixedPointPkg::activation_t [0:hiddenCount-1][0:featureCount-1]
		hiddenWeights = '{
		'{  3121,  -1874,    652,   4410,  -2937,   1508,   7021,   -356,
		    2244,  -5113,    918,   3367,  -1402,   2780,   -611},
		'{ -4402,   2716,   5530,  -1189,    843,  -3650,   1977,   6204,
		   -2518,    377,   4089,   -903,  -6120,   1455,   3302},
		'{  1290,   4875,  -3311,   2097,   6648,   -741,  -2286,   1733,
		    5019,  -4460,   2608,   1164,   -838,  -3927,   4731},
		'{ -1733,  -5262,   2849,   3976,  -1108,   4423,    608,  -2971,
		    1886,   3534,  -6701,   2215,   5107,   -489,   1372},
		'{  5864,   1027,  -2643,  -3785,   2411,    917,   3658,   4296,
		   -1520,   2063,   -774,  -3149,   1831,   6485,  -2097},
		'{  -892,   3440,   1615,  -5037,   4788,   2552,  -1349,    763,
		    6319,  -2208,   1493,   4970,  -3586,    291,  -4125},
		'{ -2920,   5669,   7442,   2905,   3415,   3193,  -4586,  -1474,
		     -79,   4600,   3581,  -4228,   2853,   2082,  -2428},
		'{  2476,  -3108,   4217,   1569,  -6032,   3891,   2734,  -1826,
		   -4371,   5296,    642,   1788,  -2915,   3603,    985}
	};

	localparam fixedPointPkg::activation_t [0:hiddenCount-1] hiddenBiases = '{
		412, -257, 138, 690, -533, 221, 309, -76
	};

	// ------------------------------------------------------------------------
	// output layer
	// ------------------------------------------------------------------------
	localparam fixedPointPkg::activation_t [0:classCount-1][0:hiddenCount-1]
		outputWeights = '{
		'{  4821,  -2264,   3107,   1589,  -3875,   2430,   5116,  -1742},
		'{ -1936,   4550,   -871,   3264,   2798,  -4012,   1377,   3689},
		'{  2603,   1841,   4375,  -3120,   1466,   3052,  -2589,   2214}
	};

	localparam fixedPointPkg::activation_t [0:classCount-1] outputBiases = '{
		187, -94, 63
	};

endpackage

`default_nettype wire

// File: design/neuron.sv
`default_nettype none

// one fixed-weight neuron: input regs, weighted sum reg, ReLU output reg
module neuron #(
	parameter int inputCount = 1,
	parameter fixedPointPkg::activation_t [0:inputCount-1] weights = '0,
	parameter fixedPointPkg::activation_t bias = '0
) (
	input logic clk,
	input logic reset,
	input fixedPointPkg::activation_t [inputCount-1:0] inputs,
	output fixedPointPkg::activation_t activationOut
);

	fixedPointPkg::activation_t [inputCount-1:0] inputReg;
	fixedPointPkg::activation_t weightedSum;
	fixedPointPkg::activation_t sumReg;

	// negative sums clamp to zero, otherwise keep bits 28..13
	function automatic fixedPointPkg::activation_t rescaledRelu(
		input fixedPointPkg::activation_t sum
	);
		logic [fixedPointPkg::keptBits-1:0] kept;
		kept = sum[fixedPointPkg::fracBits +: fixedPointPkg::keptBits];
		if (sum[fixedPointPkg::activationWidth-1])
			return '0;
		return fixedPointPkg::activation_t'(kept);
	endfunction

	// ------------------------------------------------------------------------
	// multiply-accumulate, all modulo 2^32
	// ------------------------------------------------------------------------
	always_comb
	begin
		weightedSum = bias;
		for (int i = 0; i < inputCount; i++)
			weightedSum += inputReg[i] * weights[i]; // low 32 bits of product
	end

	// ------------------------------------------------------------------------
	// pipeline registers
	// ------------------------------------------------------------------------
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			inputReg <= '0;
			sumReg <= '0;
			activationOut <= '0;
		end
		else
		begin
			inputReg <= inputs; // stage 1
			sumReg <= weightedSum; // stage 2
			activationOut <= rescaledRelu(sumReg); // stage 3
		end
	end

endmodule

`default_nettype wire

// File: design/denseLayer.sv
`default_nettype none

// fully connected layer, every neuron sees the whole input vector
module denseLayer #(
	parameter int inputCount = 1,
	parameter int neuronCount = 1,
	parameter fixedPointPkg::activation_t [0:neuronCount-1][0:inputCount-1] weightTable = '0,
	parameter fixedPointPkg::activation_t [0:neuronCount-1] biasTable = '0
) (
	input logic clk,
	input logic reset,
	input fixedPointPkg::activation_t [inputCount-1:0] layerInputs,
	output fixedPointPkg::activation_t [neuronCount-1:0] layerOutputs
);

	// one neuron per weight row
	for (genvar n = 0; n < neuronCount; n++)
	begin : neuronGen
		neuron #(
			.inputCount (inputCount),
			.weights    (weightTable[n]),
			.bias       (biasTable[n])
		) neuron_inst (
			.clk           (clk),
			.reset         (reset),
			.inputs        (layerInputs),
			.activationOut (layerOutputs[n])
		);
	end

endmodule

`default_nettype wire

// File: design/argmaxUnit.sv
`default_nettype none

// picks the largest class score, lowest class number wins a tie
module argmaxUnit (
	input logic clk,
	input logic reset,
	input fixedPointPkg::activation_t [networkPkg::classCount-1:0] scores,
	output networkPkg::classIndex_t winningClass,
	output fixedPointPkg::activation_t winningScore
);

	networkPkg::classIndex_t bestClass;
	fixedPointPkg::activation_t bestScore;

	always_comb
	begin
		bestClass = '0;
		bestScore = scores[0];
		for (int c = 1; c < networkPkg::classCount; c++)
		begin
			if (scores[c] > bestScore) // strict compare keeps the lower index on ties
			begin
				bestClass = networkPkg::classIndex_t'(c);
				bestScore = scores[c];
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			winningClass <= '0;
			winningScore <= '0;
		end
		else
		begin
			winningClass <= bestClass;
			winningScore <= bestScore;
		end
	end

endmodule

`default_nettype wire

// File: design/mlpClassifier.sv
`default_nettype none

// 15-8-3 classifier: hidden layer, output layer, argmax
module mlpClassifier (
	input logic clk,
	input logic reset,
	input fixedPointPkg::activation_t [networkPkg::featureCount-1:0] features,
	output fixedPointPkg::activation_t [networkPkg::classCount-1:0] classScores,
	output networkPkg::classIndex_t winningClass,
	output fixedPointPkg::activation_t winningScore
);

	fixedPointPkg::activation_t [networkPkg::hiddenCount-1:0] hiddenActivations;

	// ------------------------------------------------------------------------
	// layers, three cycles each
	// ------------------------------------------------------------------------
	denseLayer #(
		.inputCount  (networkPkg::featureCount),
		.neuronCount (networkPkg::hiddenCount),
		.weightTable (networkPkg::hiddenWeights),
		.biasTable   (networkPkg::hiddenBiases)
	) hiddenLayer_inst (
		.clk          (clk),
		.reset        (reset),
		.layerInputs  (features),
		.layerOutputs (hiddenActivations)
	);

	denseLayer #(
		.inputCount  (networkPkg::hiddenCount),
		.neuronCount (networkPkg::classCount),
		.weightTable (networkPkg::outputWeights),
		.biasTable   (networkPkg::outputBiases)
	) outputLayer_inst (
		.clk          (clk),
		.reset        (reset),
		.layerInputs  (hiddenActivations),
		.layerOutputs (classScores)
	);

	argmaxUnit argmaxUnit_inst (
		.clk          (clk),
		.reset        (reset),
		.scores       (classScores),
		.winningClass (winningClass),
		.winningScore (winningScore) // one edge after classScores
	);

endmodule

`default_nettype wire

// File: testbench/mlpClassifier_asserts.sv
`default_nettype none

module mlpClassifier_asserts (
	input logic clk,
	input logic reset,
	input fixedPointPkg::activation_t [networkPkg::classCount-1:0] classScores,
	input networkPkg::classIndex_t winningClass,
	input fixedPointPkg::activation_t winningScore
);

	timeunit 1ns;
	timeprecision 1ps;

	int failureCount = 0; // failed assertions so far

	// ------------------------------------------------------------------------
	// per class score checks
	// ------------------------------------------------------------------------
	for (genvar c = 0; c < networkPkg::classCount; c++)
	begin : scoreChecks
		// rescaled ReLU keeps 16 bits, the rest is zero
		upperBitsZero: assert property (@(posedge clk) disable iff (reset)
			classScores[c][fixedPointPkg::activationWidth-1:fixedPointPkg::keptBits] == '0)
		else
		begin
			failureCount++;
			$error("class score has nonzero upper bits");
		end

		winnerNotSmaller: assert property (@(posedge clk) disable iff (reset)
			winningScore >= $past(classScores[c]))
		else
		begin
			failureCount++;
			$error("winning score below a score of the previous cycle");
		end
	end

	classInRange: assert property (@(posedge clk) disable iff (reset)
		32'(winningClass) < networkPkg::classCount)
	else
	begin
		failureCount++;
		$error("winning class out of range");
	end

	resetClears: assert property (@(posedge clk)
		reset |=> (classScores == '0 && winningScore == '0 && winningClass == '0))
	else
	begin
		failureCount++;
		$error("outputs not cleared by reset");
	end

endmodule

bind mlpClassifier mlpClassifier_asserts mlpClassifierAsserts_inst (
	.clk          (clk),
	.reset        (reset),
	.classScores  (classScores),
	.winningClass (winningClass),
	.winningScore (winningScore)
);

`default_nettype wire

// File: testbench/mlpClassifierTb.sv
`default_nettype none

module mlpClassifierTb;

	timeunit 1ns;
	timeprecision 1ps;

	// features driven at an edge are sampled one edge later, then two layers
	localparam int checkDelayScores = 2 * networkPkg::neuronLatency; // drive edge to classScores
	localparam int checkDelayWinner = checkDelayScores + 1; // one more for the argmax register

	logic clk;
	logic reset;
	fixedPointPkg::activation_t [networkPkg::featureCount-1:0] features;
	fixedPointPkg::activation_t [networkPkg::classCount-1:0] classScores;
	networkPkg::classIndex_t winningClass;
	fixedPointPkg::activation_t winningScore;

	// test table read from the data file
	string testNames[$];
	fixedPointPkg::activation_t [networkPkg::featureCount-1:0] testFeatures[$];
	fixedPointPkg::activation_t [networkPkg::classCount-1:0] testScores[$];
	int testClasses[$];
	bit testsLoaded = 1'b0;

	// expected values waiting for their output edge
	string scoreNameQ[$];
	int scoreEdgeQ[$];
	fixedPointPkg::activation_t [networkPkg::classCount-1:0] scoreExpQ[$];
	string winNameQ[$];
	int winEdgeQ[$];
	int winClassQ[$];
	fixedPointPkg::activation_t winScoreQ[$];

	int edgeCount = 0;

	mlpClassifier mlpClassifier_inst (
		.clk          (clk),
		.reset        (reset),
		.features     (features),
		.classScores  (classScores),
		.winningClass (winningClass),
		.winningScore (winningScore)
	);

	// ------------------------------------------------------------------------
	// clock and edge counter
	// ------------------------------------------------------------------------
	initial
	begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	always @(posedge clk)
		edgeCount <= edgeCount + 1;

	// ------------------------------------------------------------------------
	// failure reporting
	// ------------------------------------------------------------------------
	task automatic failRun(input string reason);
		$display("%s", reason);
		$display("Simulation finished: FAIL");
		$fatal(1, "run stopped");
	endtask

	task automatic reportMismatch(input string testName, input string what,
		input logic [31:0] expected, input logic [31:0] actual);
		$display("** Error: test %s, %s expected %0h, actual %0h",
			testName, what, expected, actual);
		failRun("value mismatch");
	endtask

	// largest score, lower class number wins a tie
	function automatic fixedPointPkg::activation_t largestScore(
		input fixedPointPkg::activation_t [networkPkg::classCount-1:0] scores
	);
		fixedPointPkg::activation_t best;
		best = scores[0];
		for (int c = 1; c < networkPkg::classCount; c++)
			if (scores[c] > best)
				best = scores[c];
		return best;
	endfunction

	// ------------------------------------------------------------------------
	// data file
	// ------------------------------------------------------------------------
	task automatic loadTests();
		int fd;
		int fieldCount;
		int cls;
		string line;
		string name;
		logic [31:0] f [networkPkg::featureCount];
		logic [31:0] s [networkPkg::classCount];
		fixedPointPkg::activation_t [networkPkg::featureCount-1:0] packedF;
		fixedPointPkg::activation_t [networkPkg::classCount-1:0] packedS;
		fd = $fopen("testbench/mlp_tests.txt", "r");
		if (fd == 0)
			failRun("could not open the test file testbench/mlp_tests.txt");
		while ($fgets(line, fd) != 0)
		begin
			if (line.len() < 2 || line.substr(0, 0) == "#")
				continue; // comment or blank line
			fieldCount = $sscanf(line,
				"%s %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %d",
				name, f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8],
				f[9], f[10], f[11], f[12], f[13], f[14], s[0], s[1], s[2], cls);
			if (fieldCount != 20)
				failRun({"malformed line in the test file: ", line});
			for (int i = 0; i < networkPkg::featureCount; i++)
				packedF[i] = f[i];
			for (int c = 0; c < networkPkg::classCount; c++)
				packedS[c] = s[c];
			testNames.push_back(name);
			testFeatures.push_back(packedF);
			testScores.push_back(packedS);
			testClasses.push_back(cls);
		end
		$fclose(fd);
		if (testNames.size() == 0)
			failRun("the test file holds no tests");
	endtask

	task automatic pushExpected(input string name,
		input fixedPointPkg::activation_t [networkPkg::classCount-1:0] scores,
		input int cls, input int driveEdge);
		scoreNameQ.push_back(name);
		scoreEdgeQ.push_back(driveEdge);
		scoreExpQ.push_back(scores);
		winNameQ.push_back(name);
		winEdgeQ.push_back(driveEdge);
		winClassQ.push_back(cls);
		winScoreQ.push_back(largestScore(scores));
	endtask

	// ------------------------------------------------------------------------
	// stimulus
	// ------------------------------------------------------------------------
	initial
	begin
		reset = 1'b1;
		features = '0;
		void'($urandom(32'h94c6));
		loadTests();
		testsLoaded = 1'b1;
		repeat (2) @(posedge clk);
		reset <= 1'b0;
		for (int t = 0; t < testNames.size(); t++)
		begin
			@(posedge clk);
			features <= testFeatures[t];
			pushExpected(testNames[t], testScores[t], testClasses[t], edgeCount + 1);
			if (t < testNames.size() - 1 && $urandom % 2 == 1)
			begin
				@(posedge clk); // idle cycle, zero features give zero outputs
				features <= '0;
				pushExpected("idle", '0, 0, edgeCount + 1);
			end
		end
		@(posedge clk);
		features <= '0;
		wait (winNameQ.size() == 0);
		@(negedge clk);
		if (mlpClassifier_inst.mlpClassifierAsserts_inst.failureCount == 0)
		begin
			$display("Simulation finished: PASS");
			$finish;
		end
		else
			failRun("a concurrent assertion on the DUT outputs failed");
	end

	// ------------------------------------------------------------------------
	// checks, sampled on the falling edge
	// ------------------------------------------------------------------------
	always @(negedge clk)
	begin
		assert (mlpClassifier_inst.mlpClassifierAsserts_inst.failureCount == 0)
		else failRun("a concurrent assertion on the DUT outputs failed");
		if (edgeCount >= 1 && edgeCount <= 3) // reset and the cycle after it
		begin
			for (int c = 0; c < networkPkg::classCount; c++)
				assert (classScores[c] == '0)
				else reportMismatch("reset", $sformatf("score %0d", c), '0, classScores[c]);
			assert (winningScore == '0)
			else reportMismatch("reset", "winningScore", '0, winningScore);
			assert (winningClass == '0)
			else reportMismatch("reset", "winningClass", '0, 32'(winningClass));
		end
		if (scoreEdgeQ.size() > 0 && edgeCount == scoreEdgeQ[0] + checkDelayScores)
		begin
			for (int c = 0; c < networkPkg::classCount; c++)
				assert (classScores[c] == scoreExpQ[0][c])
				else reportMismatch(scoreNameQ[0], $sformatf("score %0d", c),
					scoreExpQ[0][c], classScores[c]);
			void'(scoreNameQ.pop_front());
			void'(scoreEdgeQ.pop_front());
			void'(scoreExpQ.pop_front());
		end
		if (winEdgeQ.size() > 0 && edgeCount == winEdgeQ[0] + checkDelayWinner)
		begin
			assert (32'(winningClass) == winClassQ[0])
			else reportMismatch(winNameQ[0], "winningClass", winClassQ[0],
				32'(winningClass));
			assert (winningScore == winScoreQ[0])
			else reportMismatch(winNameQ[0], "winningScore", winScoreQ[0], winningScore);
			void'(winNameQ.pop_front());
			void'(winEdgeQ.pop_front());
			void'(winClassQ.pop_front());
			void'(winScoreQ.pop_front());
		end
	end

	// each test takes at most two cycles, plus reset and pipeline drain
	initial
	begin
		int limit;
		wait (testsLoaded);
		limit = (testNames.size() * 2 + 20) * 4;
		#(limit);
		failRun("watchdog timeout, the expected results did not all arrive");
	end

endmodule

`default_nettype wire

// File: testbench/mlp_tests.txt
# columns: name, features 0..14 (hex), expected scores 0..2 (hex), expected class (decimal)
# expected scores follow the fixed-point rule, ReLU keeps sum bits 28..13
#
# all features zero, biases are too small to pass the ReLU, all classes tie
zeroFeatures 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
# feature 6 = 8, small hidden activations
col6Small 0 0 0 0 0 0 8 0 0 0 0 0 0 0 0 1 1 3 2
# feature 6 = 8192, hidden values close to the weights
col6Large 0 0 0 0 0 0 2000 0 0 0 0 0 0 0 0 570 870 efc 2
# feature 0 = 16, class 0 sum is negative and clamps to 0
col0Clamp 10 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 3 6 2
# feature 1 = 16
col1Mid 0 10 0 0 0 0 0 0 0 0 0 0 0 0 0 a 1 4 0
# feature 3 = 16
col3Mid 0 0 0 10 0 0 0 0 0 0 0 0 0 0 0 a 2 1 0
# feature 4 = 16, classes 0 and 2 tie on the top score
col4Tie 0 0 0 0 10 0 0 0 0 0 0 0 0 0 0 9 0 9 0
# feature 2 = 16, class 2 sum is negative
col2Mid 0 0 10 0 0 0 0 0 0 0 0 0 0 0 0 6 b 0 1
# feature 6 = -8, negative weights now give positive hidden sums
col6Negative 0 0 0 0 0 0 fffffff8 0 0 0 0 0 0 0 0 3 0 0 0
#
# repeated vectors, streamed close together
col6LargeAgain 0 0 0 0 0 0 2000 0 0 0 0 0 0 0 0 570 870 efc 2
col0ClampAgain 10 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 3 6 2
zeroAgain 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
col4TieAgain 0 0 0 0 10 0 0 0 0 0 0 0 0 0 0 9 0 9 0
col1MidAgain 0 10 0 0 0 0 0 0 0 0 0 0 0 0 0 a 1 4 0
col2MidAgain 0 0 10 0 0 0 0 0 0 0 0 0 0 0 0 6 b 0 1
col6SmallAgain 0 0 0 0 0 0 8 0 0 0 0 0 0 0 0 1 1 3 2
col3MidAgain 0 0 0 10 0 0 0 0 0 0 0 0 0 0 0 a 2 1 0
col6NegativeAgain 0 0 0 0 0 0 fffffff8 0 0 0 0 0 0 0 0 3 0 0 0

// File: verilog.f
design/fixedPointPkg.sv
design/networkPkg.sv
design/neuron.sv
design/denseLayer.sv
design/argmaxUnit.sv
design/mlpClassifier.sv
testbench/mlpClassifier_asserts.sv
testbench/mlpClassifierTb.sv

// File: Makefile
VERILATOR ?= verilator
FLAGS     = --binary --timing --assert -Wno-fatal
TOP       = mlpClassifierTb
FILELIST  = verilog.f
BUILD_DIR = obj_dir
LOG       = sim.log
PASS_TEXT = Simulation finished: PASS

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
